// File: flist.f
hdl/dmem_pkg.sv
hdl/fpgaio_pkg.sv
hdl/store_lane_decode.sv
hdl/byte_lane_ram.sv
hdl/fpgaio_regs.sv
hdl/load_return_mux.sv
hdl/datamem.sv
test/tb_datamem.sv

// File: Bender.yml
package:
  name: datamem

sources:
  # Packages first, then leaf modules and the top level
  - hdl/dmem_pkg.sv
  - hdl/fpgaio_pkg.sv
  - hdl/store_lane_decode.sv
  - hdl/byte_lane_ram.sv
  - hdl/fpgaio_regs.sv
  - hdl/load_return_mux.sv
  - hdl/datamem.sv

  - target: test
    files:
      - test/tb_datamem.sv

// File: test/tb_datamem.sv
`default_nettype none

module tb_datamem
	import dmem_pkg::*, fpgaio_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 5;
	localparam int N_CORE = 200;
	localparam int N_CROSS = 100;
	localparam int N_LED = 50;
	localparam int N_IO = 30;
	localparam int N_RF = 50;
	// Cycles of all tests, two drain cycles per test included
	localparam int TEST_CYCLES = 4 + RAM_DEPTH / 2 + 2 * N_CORE + 3 * N_CROSS
		+ 2 * N_LED + 1 + 2 * N_IO + 4 + 2 * N_RF + 7 * 2;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 2 + TEST_CYCLES);

	logic clk;
	logic nrst;
	strb_t dm_write;
	core_addr_t exe_data_addr;
	core_addr_t mem_data_addr;
	word_t data_in;
	btn_t btn;
	sw_t sw;
	strb_t con_write;
	ram_addr_t con_addr;
	word_t con_in;
	wire led_t led;
	wire word_t data_out;
	wire word_t con_out;

	// Reference model of RAM and LED word
	word_t ref_mem [RAM_DEPTH];
	logic known [RAM_DEPTH];
	word_t led_model;

	// Reads issued last cycle, answered in this one
	core_addr_t prev_exe_addr;
	word_t prev_ram_rd;
	logic prev_ram_known;
	word_t prev_con_rd;
	logic prev_con_known;
	btn_t prev_btn;
	sw_t prev_sw;
	btn_t btn_next;
	sw_t sw_next;

	// Expected responses for the current cycle
	word_t exp_data;
	logic exp_data_vld;
	word_t exp_con;
	logic exp_con_vld;
	led_t exp_led;
	logic exp_led_vld;

	logic [31:0] lcg_state;
	int err_cnt;
	int err_at_start;
	int pass_cnt;
	int fail_cnt;
	int cycle_cnt;

	datamem u_datamem (
		.clk(clk),
		.nrst(nrst),
		.dm_write(dm_write),
		.exe_data_addr(exe_data_addr),
		.mem_data_addr(mem_data_addr),
		.data_in(data_in),
		.btn(btn),
		.sw(sw),
		.led(led),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.data_out(data_out),
		.con_out(con_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// sw, aligned sh or sb
	function automatic strb_t pick_strb(input logic [31:0] r);
		case (r % 7)
			0: return 4'b1111;
			1: return 4'b0011;
			2: return 4'b1100;
			3: return 4'b0001;
			4: return 4'b0010;
			5: return 4'b0100;
			default: return 4'b1000;
		endcase
	endfunction

	// Strobed bytes take new data
	function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t s);
		word_t res;
		res = old_w;
		for (int k = 0; k < NUM_LANES; k++) begin
			if (s[k]) begin
				res[k*8 +: 8] = new_w[k*8 +: 8];
			end
		end
		return res;
	endfunction

	// Memory map of the I/O window
	function automatic word_t io_read_value(input core_addr_t a);
		if (a == 11'h400) return {28'd0, prev_btn};
		if (a == 11'h401) return {29'd0, prev_sw};
		if (a == 11'h402) return led_model;
		return 32'd0;
	endfunction

	// One clock of stimulus, driven at the falling edge
	task automatic drive_cycle(input strb_t c_strb, input core_addr_t c_addr, input word_t c_data,
		input strb_t p_strb, input ram_addr_t p_addr, input word_t p_data);
		ram_addr_t c_ram;
		@(negedge clk);
		// Answers to last cycle's reads
		exp_led = led_model[3:0];
		exp_led_vld = 1'b1;
		exp_con = prev_con_rd;
		exp_con_vld = prev_con_known;
		exp_data_vld = 1'b1;
		if (!prev_exe_addr[10]) begin
			exp_data = prev_ram_rd;
			exp_data_vld = prev_ram_known;
		end else begin
			exp_data = io_read_value(prev_exe_addr);
		end
		// Pipeline moves execute address to memory stage
		mem_data_addr = prev_exe_addr;
		exe_data_addr = c_addr;
		dm_write = c_strb;
		data_in = c_data;
		con_write = p_strb;
		con_addr = p_addr;
		con_in = p_data;
		btn = btn_next;
		sw = sw_next;
		// Read-first, model sampled before the stores
		c_ram = c_addr[9:0];
		prev_ram_rd = ref_mem[c_ram];
		prev_ram_known = known[c_ram];
		prev_con_rd = ref_mem[p_addr];
		prev_con_known = known[p_addr];
		prev_exe_addr = c_addr;
		prev_btn = btn_next;
		prev_sw = sw_next;
		// Core stores, I/O window never reaches RAM
		if (c_strb != '0 && !c_addr[10]) begin
			ref_mem[c_ram] = merge_bytes(ref_mem[c_ram], c_data, c_strb);
			known[c_ram] = known[c_ram] | (c_strb == 4'hf);
		end else if (c_strb != '0 && c_addr == 11'h402) begin
			led_model = merge_bytes(led_model, c_data, c_strb);
		end
		if (p_strb != '0) begin
			ref_mem[p_addr] = merge_bytes(ref_mem[p_addr], p_data, p_strb);
			known[p_addr] = known[p_addr] | (p_strb == 4'hf);
		end
	endtask

	task automatic idle_cycle();
		drive_cycle('0, 11'h000, '0, '0, 10'h000, '0);
	endtask

	task automatic begin_test();
		err_at_start = err_cnt;
	endtask

	// Drain so late checks count for this test
	task automatic end_test(input string name);
		idle_cycle();
		idle_cycle();
		if (err_cnt == err_at_start) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, err_cnt - err_at_start);
		end
	endtask

	task automatic run_tests();
		logic [31:0] r;
		ram_addr_t a;
		ram_addr_t b;
		// Reset values of LED and sampled inputs
		begin_test();
		drive_cycle('0, 11'h400, '0, '0, '0, '0);
		drive_cycle('0, 11'h401, '0, '0, '0, '0);
		drive_cycle('0, 11'h402, '0, '0, '0, '0);
		drive_cycle('0, 11'h400, '0, '0, '0, '0);
		end_test("reset_io");
		// Fill RAM, both ports writing different halves
		begin_test();
		for (int i = 0; i < RAM_DEPTH / 2; i++) begin
			drive_cycle(4'hf, core_addr_t'(RAM_DEPTH / 2 + i), next_rand(),
				4'hf, ram_addr_t'(i), next_rand());
		end
		end_test("preload");
		// Random core stores, each read back
		begin_test();
		for (int i = 0; i < N_CORE; i++) begin
			r = next_rand();
			drive_cycle(pick_strb(r >> 16), {1'b0, r[9:0]}, next_rand(), '0, r[25:16], '0);
			drive_cycle('0, {1'b0, r[9:0]}, '0, '0, r[31:22], '0);
		end
		end_test("core_rand");
		// Protocol writes seen by core and back
		begin_test();
		for (int i = 0; i < N_CROSS; i++) begin
			r = next_rand();
			a = r[9:0];
			b = a ^ 10'h200;
			drive_cycle(pick_strb(r >> 16), {1'b0, b}, next_rand(), 4'hf, a, next_rand());
			drive_cycle('0, {1'b0, a}, '0, '0, b, '0);
			drive_cycle('0, {1'b0, b}, '0, '0, a, '0);
		end
		end_test("port_cross");
		// LED byte merge, RAM word 0x002 untouched
		begin_test();
		for (int i = 0; i < N_LED; i++) begin
			r = next_rand();
			drive_cycle(pick_strb(r), 11'h402, next_rand(), '0, '0, '0);
			drive_cycle('0, 11'h402, '0, '0, '0, '0);
		end
		drive_cycle('0, 11'h002, '0, '0, 10'h002, '0);
		end_test("led_store");
		// Board inputs, unmapped I/O words
		begin_test();
		for (int i = 0; i < N_IO; i++) begin
			r = next_rand();
			// Fresh board inputs every cycle
			btn_next = r[3:0];
			sw_next = r[6:4];
			drive_cycle('0, 11'h400, '0, '0, '0, '0);
			btn_next = r[11:8];
			sw_next = r[14:12];
			drive_cycle('0, 11'h401, '0, '0, '0, '0);
		end
		drive_cycle(4'hf, 11'h7ff, next_rand(), '0, '0, '0);
		drive_cycle('0, 11'h403, '0, '0, '0, '0);
		drive_cycle('0, 11'h7ff, '0, '0, '0, '0);
		drive_cycle('0, 11'h3ff, '0, '0, 10'h3ff, '0);
		end_test("io_inputs");
		// Same-cycle read and write of one word
		begin_test();
		for (int i = 0; i < N_RF; i++) begin
			r = next_rand();
			drive_cycle(pick_strb(r >> 16), {1'b0, r[9:0]}, next_rand(), '0, r[9:0], '0);
			drive_cycle('0, {1'b0, r[9:0]}, '0, '0, r[9:0], '0);
		end
		end_test("read_first");
	endtask

	// Checks against the model, one cycle after each access
	a_data_out: assert property (
		@(posedge clk) disable iff (!nrst)
		exp_data_vld |-> (data_out === exp_data)
	) else begin
		err_cnt++;
		$display("Mismatch at %0t: data_out %h, expected %h", $time,
			$sampled(data_out), $sampled(exp_data));
	end

	a_con_out: assert property (
		@(posedge clk) disable iff (!nrst)
		exp_con_vld |-> (con_out === exp_con)
	) else begin
		err_cnt++;
		$display("Mismatch at %0t: con_out %h, expected %h", $time,
			$sampled(con_out), $sampled(exp_con));
	end

	a_led: assert property (
		@(posedge clk) disable iff (!nrst)
		exp_led_vld |-> (led === exp_led)
	) else begin
		err_cnt++;
		$display("Mismatch at %0t: led %h, expected %h", $time, $sampled(led), $sampled(exp_led));
	end

	// Hung run guard
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		nrst = 1'b0;
		dm_write = '0;
		exe_data_addr = '0;
		mem_data_addr = '0;
		data_in = '0;
		btn = '0;
		sw = '0;
		con_write = '0;
		con_addr = '0;
		con_in = '0;
		btn_next = '0;
		sw_next = '0;
		led_model = '0;
		prev_exe_addr = '0;
		prev_ram_rd = '0;
		prev_ram_known = 1'b0;
		prev_con_rd = '0;
		prev_con_known = 1'b0;
		prev_btn = '0;
		prev_sw = '0;
		exp_data = '0;
		exp_data_vld = 1'b0;
		exp_con = '0;
		exp_con_vld = 1'b0;
		exp_led = '0;
		exp_led_vld = 1'b0;
		lcg_state = 32'h7153;
		err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		// RAM content unknown until written
		for (int i = 0; i < RAM_DEPTH; i++) begin
			ref_mem[i] = '0;
			known[i] = 1'b0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		run_tests();
		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/datamem.sv
`default_nettype none

module datamem
	import dmem_pkg::*, fpgaio_pkg::*;
(
	input wire clk,
	input wire nrst,

	// Core side
	input wire strb_t dm_write,
	input wire core_addr_t exe_data_addr,
	input wire core_addr_t mem_data_addr,
	input wire word_t data_in,

	// Board I/O
	input wire btn_t btn,
	input wire sw_t sw,
	output led_t led,

	// Protocol controller side, RAM only
	input wire strb_t con_write,
	input wire ram_addr_t con_addr,
	input wire word_t con_in,

	output word_t data_out,
	output wire word_t con_out
);

	strb_t core_we;
	strb_t con_we;
	strb_t led_mask;
	ram_addr_t core_ram_addr;
	wire word_t ram_core_word;
	word_t btn_word;
	word_t sw_word;
	word_t led_word;

	// Lanes see the RAM part of the execute address
	assign core_ram_addr = exe_data_addr[RAM_AW-1:0];

	store_lane_decode u_store_lane_decode (
		.clk(clk),
		.nrst(nrst),
		.dm_write(dm_write),
		.exe_data_addr(exe_data_addr),
		.con_write(con_write),
		.core_we(core_we),
		.con_we(con_we),
		.led_mask(led_mask)
	);

	// Lane k holds byte k of every word
	for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
		byte_lane_ram u_byte_lane_ram (
			.clk(clk),
			.core_we(core_we[k]),
			.core_addr(core_ram_addr),
			.core_wdata(data_in[k*BYTE_W +: BYTE_W]),
			.core_rdata(ram_core_word[k*BYTE_W +: BYTE_W]),
			.con_we(con_we[k]),
			.con_addr(con_addr),
			.con_wdata(con_in[k*BYTE_W +: BYTE_W]),
			.con_rdata(con_out[k*BYTE_W +: BYTE_W])
		);
	end

	fpgaio_regs u_fpgaio_regs (
		.clk(clk),
		.nrst(nrst),
		.btn(btn),
		.sw(sw),
		.led_mask(led_mask),
		.data_in(data_in),
		.btn_word(btn_word),
		.sw_word(sw_word),
		.led_word(led_word),
		.led(led)
	);

	load_return_mux u_load_return_mux (
		.mem_data_addr(mem_data_addr),
		.lane_core_rdata(ram_core_word),
		.btn_word(btn_word),
		.sw_word(sw_word),
		.led_word(led_word),
		.data_out(data_out)
	);

	// Memory-stage address steers the load mux
	// must be known once out of reset
	a_mem_addr_known: assert property (
		@(posedge clk) disable iff (!nrst)
		!$isunknown(mem_data_addr)
	) else $error("unknown memory-stage address %h", mem_data_addr);

endmodule

`default_nettype wire

// File: hdl/load_return_mux.sv
`default_nettype none

module load_return_mux
	import dmem_pkg::*, fpgaio_pkg::*;
(
	// Memory-stage address, one cycle after execute
	input wire core_addr_t mem_data_addr,

	// RAM word read at the execute address
	input wire word_t lane_core_rdata,

	// Mapped I/O words
	input wire word_t btn_word,
	input wire word_t sw_word,
	input wire word_t led_word,

	// Load data to the core, full word
	output word_t data_out
);

	logic in_io;

	// Region bit picks RAM or I/O
	assign in_io = mem_data_addr[IO_REGION_BIT];

	always_comb begin
		if (!in_io) begin
			// Registered lane output
			data_out = lane_core_rdata;
		end else begin
			case (mem_data_addr)
				IO_BTN_ADDR: data_out = btn_word;
				IO_SW_ADDR: data_out = sw_word;
				IO_LED_ADDR: data_out = led_word;
				// Unmapped I/O words read as zero
				default: data_out = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/fpgaio_regs.sv
`default_nettype none

module fpgaio_regs
	import dmem_pkg::*, fpgaio_pkg::*;
(
	input wire clk,
	input wire nrst,

	// Board inputs, asynchronous to the core
	input wire btn_t btn,
	input wire sw_t sw,

	// LED store from the decoder
	input wire strb_t led_mask,
	input wire word_t data_in,

	// Mapped words for the load path
	output word_t btn_word,
	output word_t sw_word,
	output word_t led_word,

	// Board LEDs
	output led_t led
);

	// Buttons and switches sampled every cycle
	// zero-extended to a full word
	always_ff @(posedge clk) begin
		if (!nrst) begin
			btn_word <= '0;
			sw_word <= '0;
		end else begin
			btn_word <= word_t'(btn);
			sw_word <= word_t'(sw);
		end
	end

	// LED word, byte merge under the store mask
	always_ff @(posedge clk) begin
		if (!nrst) begin
			led_word <= '0;
		end else begin
			for (int k = 0; k < NUM_LANES; k++) begin
				// Untouched bytes keep their value
				if (led_mask[k]) begin
					led_word[k*BYTE_W +: BYTE_W] <= data_in[k*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// Low bits drive the board
	assign led = led_word[LED_W-1:0];

endmodule

`default_nettype wire

// File: hdl/byte_lane_ram.sv
`default_nettype none

module byte_lane_ram
	import dmem_pkg::*;
(
	input wire clk,

	// Core port
	input wire core_we,
	input wire ram_addr_t core_addr,
	input wire byte_t core_wdata,
	output byte_t core_rdata,

	// Protocol port
	input wire con_we,
	input wire ram_addr_t con_addr,
	input wire byte_t con_wdata,
	output byte_t con_rdata
);

	// One byte of every RAM word
	byte_t mem [RAM_DEPTH];

	// Core port
	// read-first, old byte out on a same-edge write
	always @(posedge clk) begin
		if (core_we) begin
			mem[core_addr] <= core_wdata;
		end
		core_rdata <= mem[core_addr];
	end

	// Protocol port, same read-first behaviour
	always @(posedge clk) begin
		if (con_we) begin
			mem[con_addr] <= con_wdata;
		end
		con_rdata <= mem[con_addr];
	end

	// Both ports writing one word is a collision
	// result undefined, so the ports must keep apart
	a_no_write_collision: assert property (
		@(posedge clk)
		!(core_we && con_we && (core_addr == con_addr))
	) else $error("both ports wrote word %h in one cycle", core_addr);

endmodule

`default_nettype wire

// File: hdl/store_lane_decode.sv
`default_nettype none

module store_lane_decode
	import dmem_pkg::*, fpgaio_pkg::*;
(
	input wire clk,
	input wire nrst,

	// Core store, execute stage
	input wire strb_t dm_write,
	input wire core_addr_t exe_data_addr,

	// Protocol controller store
	input wire strb_t con_write,

	// Per-lane enables toward the RAM lanes
	output strb_t core_we,
	output strb_t con_we,

	// Byte enables for the LED word
	output strb_t led_mask
);

	logic in_io;

	// Word, aligned half or single byte
	function automatic logic legal_strb(input strb_t s);
		case (s)
			4'b1111,
			4'b0011, 4'b1100,
			4'b0001, 4'b0010, 4'b0100, 4'b1000: legal_strb = 1'b1;
			default: legal_strb = 1'b0;
		endcase
	endfunction

	// Region bit set means an I/O access
	assign in_io = exe_data_addr[IO_REGION_BIT];

	// I/O stores never alias into the RAM
	assign core_we = in_io ? '0 : dm_write;

	// LED is the only writable I/O word
	// stores to other I/O words are dropped
	assign led_mask = (exe_data_addr == IO_LED_ADDR) ? dm_write : '0;

	// Protocol side reaches RAM only, same strobe layout
	assign con_we = con_write;

	// Core must issue sb, sh or sw patterns only
	a_core_strb_legal: assert property (
		@(posedge clk) disable iff (!nrst)
		(dm_write != '0) |-> legal_strb(dm_write)
	) else $error("illegal core store strobe %b", dm_write);

	// Same rule for the protocol controllers
	a_con_strb_legal: assert property (
		@(posedge clk) disable iff (!nrst)
		(con_write != '0) |-> legal_strb(con_write)
	) else $error("illegal protocol store strobe %b", con_write);

endmodule

`default_nettype wire

// File: hdl/fpgaio_pkg.sv
`default_nettype none

package fpgaio_pkg;

	import dmem_pkg::*;

	// Board I/O widths
	localparam int BTN_W = 4;
	localparam int SW_W = 3;
	localparam int LED_W = 4;

	typedef logic [BTN_W-1:0] btn_t;
	typedef logic [SW_W-1:0] sw_t;
	typedef logic [LED_W-1:0] led_t;

	// Word addresses just above the RAM
	localparam core_addr_t IO_BTN_ADDR = 11'h400;
	localparam core_addr_t IO_SW_ADDR = 11'h401;
	// Only writable I/O word
	localparam core_addr_t IO_LED_ADDR = 11'h402;

endpackage

`default_nettype wire

// File: hdl/dmem_pkg.sv
`default_nettype none

package dmem_pkg;

	// Data path of the 32-bit core
	localparam int WORD_W = 32;
	localparam int BYTE_W = 8;

	// One RAM lane per byte of the word
	localparam int NUM_LANES = WORD_W / BYTE_W;

	// Core word address spans RAM plus the I/O window
	localparam int CORE_AW = 11;

	// RAM word address, shared by protocol port and lanes
	localparam int RAM_AW = 10;

	// 1024 words per lane
	localparam int RAM_DEPTH = 1 << RAM_AW;

	// Address bit just above the RAM selects I/O
	localparam int IO_REGION_BIT = RAM_AW;

	// Full data word
	typedef logic [WORD_W-1:0] word_t;

	// Byte write strobes, bit k for lane k
	typedef logic [NUM_LANES-1:0] strb_t;

	// Data of a single lane
	typedef logic [BYTE_W-1:0] byte_t;

	// Word address as seen by the core
	typedef logic [CORE_AW-1:0] core_addr_t;

	// Word address inside the RAM
	typedef logic [RAM_AW-1:0] ram_addr_t;

endpackage

`default_nettype wire
